// ==== src/debug_unit_macros.svh ====
/*
 * Widths, register count and command codes of the UART debug protocol.
 * Included by the package, the RTL and the testbench.
 */
`ifndef DEBUG_UNIT_MACROS_SVH
`define DEBUG_UNIT_MACROS_SVH

// Data widths
`define DU_BYTE_W           8       // UART byte
`define DU_WORD_W           32      // Instruction, register and PC
`define DU_BYTES_PER_WORD   4       // Bytes sent per word

// Register file seen by the dump
`define DU_REG_ADDR_W       5       // Register index width
`define DU_NUM_REGS         32      // Registers dumped before the PC

// Command bytes from the host
`define DU_CMD_LOAD         8'hFE   // Size byte then program words
`define DU_CMD_STEP         8'hFC   // One cycle then dump
`define DU_CMD_RUN          8'hF0   // Run to halt, dump, reset
`define DU_CMD_RESET        8'h30   // Software reset pulse

`endif

// ==== src/debug_unit_pkg.sv ====
/*
 * Shared types of the UART debug unit.
 * Modules name these by scope, debug_unit_pkg::type.
 */
`default_nettype none

`include "debug_unit_macros.svh"

package debug_unit_pkg;

    // Plain vectors with a meaning
    typedef logic [`DU_BYTE_W-1:0]                  byte_t;
    typedef logic [`DU_WORD_W-1:0]                  word_t;
    typedef logic [`DU_REG_ADDR_W-1:0]              reg_addr_t;
    typedef logic [`DU_BYTE_W-1:0]                  inst_count_t;    // Size byte sets the range
    typedef logic [$clog2(`DU_BYTES_PER_WORD)-1:0]  byte_sel_t;

    // Command sequencer
    typedef enum logic [2:0]
    {
        ST_CMD,         // Waiting for a command byte
        ST_LOAD,        // Forwarding program bytes
        ST_STEP,        // Single enabled cycle
        ST_RUN,         // Enabled until halt
        ST_DUMP,        // Dumper busy
        ST_RESET        // Software reset pulse
    } seq_state_t;

    // State dumper
    typedef enum logic [1:0]
    {
        DUMP_IDLE,
        DUMP_REGS,      // Registers 0 to 31
        DUMP_PC         // Program counter last
    } dump_phase_t;

endpackage

`default_nettype wire

// ==== src/cmd_sequencer.sv ====
/*
 * Main control FSM of the debug unit. Pops command bytes from the receive
 * FIFO, forwards program bytes to the loader, drives pipeline enable and
 * starts the state dump. Ends a run, or a step that hit halt, with a reset.
 */
`timescale 1ns/1ps
`default_nettype none

`include "debug_unit_macros.svh"

module cmd_sequencer
(
    input  logic                    i_clk,
    input  logic                    i_reset,

    input  logic                    i_rx_empty,         // Receive FIFO empty
    input  debug_unit_pkg::byte_t   i_rx_data,          // Head of receive FIFO
    input  logic                    i_halt,             // Pipeline halted
    input  logic                    i_load_done,        // Final program byte seen
    input  logic                    i_dump_done,        // Last dump byte written

    output logic                    o_rd,               // Pop receive FIFO
    output logic                    o_load_byte_valid,  // Program byte strobe
    output debug_unit_pkg::byte_t   o_load_byte,
    output logic                    o_dump_start,       // One-cycle dump request
    output logic                    o_enable,           // Pipeline enable
    output logic                    o_reset             // Software reset pulse
);

    debug_unit_pkg::seq_state_t state;
    debug_unit_pkg::seq_state_t state_next;
    logic                       halt_seen;              // Reset after the dump
    logic                       halt_seen_next;

    // Loader samples the byte only on the strobe
    assign o_load_byte = i_rx_data;

    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            state     <= debug_unit_pkg::ST_CMD;
            halt_seen <= 1'b0;
        end
        else
        begin
            state     <= state_next;
            halt_seen <= halt_seen_next;
        end
    end

    always_comb
    begin
        state_next        = state;
        halt_seen_next    = halt_seen;
        o_rd              = 1'b0;
        o_load_byte_valid = 1'b0;
        o_dump_start      = 1'b0;
        o_enable          = 1'b0;
        o_reset           = 1'b0;

        case (state)
            debug_unit_pkg::ST_CMD:
            begin
                if (!i_rx_empty)
                begin
                    o_rd = 1'b1;                        // Every command byte is consumed
                    case (i_rx_data)
                        `DU_CMD_LOAD:  state_next = debug_unit_pkg::ST_LOAD;
                        `DU_CMD_STEP:  state_next = debug_unit_pkg::ST_STEP;
                        `DU_CMD_RUN:   state_next = debug_unit_pkg::ST_RUN;
                        `DU_CMD_RESET: state_next = debug_unit_pkg::ST_RESET;
                        default:       state_next = debug_unit_pkg::ST_CMD;   // Unknown byte dropped
                    endcase
                end
            end

            debug_unit_pkg::ST_LOAD:
            begin
                // Stall here while the FIFO is empty
                o_rd              = !i_rx_empty;
                o_load_byte_valid = !i_rx_empty;
                if (i_load_done)
                    state_next = debug_unit_pkg::ST_CMD;
            end

            debug_unit_pkg::ST_STEP:
            begin
                o_enable       = 1'b1;
                o_dump_start   = 1'b1;
                halt_seen_next = i_halt;                // Step into halt ends with reset
                state_next     = debug_unit_pkg::ST_DUMP;
            end

            debug_unit_pkg::ST_RUN:
            begin
                if (i_halt)
                begin
                    o_dump_start   = 1'b1;
                    halt_seen_next = 1'b1;
                    state_next     = debug_unit_pkg::ST_DUMP;
                end
                else
                    o_enable = 1'b1;
            end

            debug_unit_pkg::ST_DUMP:
            begin
                if (i_dump_done)
                    state_next = halt_seen ? debug_unit_pkg::ST_RESET : debug_unit_pkg::ST_CMD;
            end

            debug_unit_pkg::ST_RESET:
            begin
                o_reset    = 1'b1;
                state_next = debug_unit_pkg::ST_CMD;
            end

            default:
                state_next = debug_unit_pkg::ST_CMD;
        endcase
    end

endmodule

`default_nettype wire

// ==== src/prog_loader.sv ====
/*
 * Builds program words from the load payload. The first byte is the
 * instruction count, then four bytes per instruction, least significant
 * first. Each finished word is written to instruction memory a cycle later.
 */
`timescale 1ns/1ps
`default_nettype none

`include "debug_unit_macros.svh"

module prog_loader
(
    input  logic                    i_clk,
    input  logic                    i_reset,

    input  logic                    i_byte_valid,   // Byte popped in ST_LOAD
    input  debug_unit_pkg::byte_t   i_byte,

    output logic                    o_load_done,    // With the final byte
    output logic                    o_write_mem,    // Instruction memory write
    output debug_unit_pkg::word_t   o_inst
);

    logic                           have_size;      // Size byte already taken
    debug_unit_pkg::inst_count_t    prog_size;
    debug_unit_pkg::inst_count_t    inst_count;     // Words completed so far
    debug_unit_pkg::byte_sel_t      byte_sel;
    debug_unit_pkg::word_t          inst_reg;
    logic                           last_byte;
    logic                           last_inst;
    logic                           write_mem;      // Word finished last cycle

    assign last_byte = (byte_sel == debug_unit_pkg::byte_sel_t'(`DU_BYTES_PER_WORD - 1));
    assign last_inst = (inst_count == prog_size - 1'b1);

    // Zero size finishes on the size byte itself
    assign o_load_done = i_byte_valid &&
                         (have_size ? (last_byte && last_inst) : (i_byte == '0));

    assign o_write_mem = write_mem;
    assign o_inst      = inst_reg;

    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            have_size  <= 1'b0;
            inst_count <= '0;
            byte_sel   <= '0;
            write_mem  <= 1'b0;
        end
        else
        begin
            write_mem <= i_byte_valid && have_size && last_byte;
            if (i_byte_valid)
            begin
                if (!have_size)
                begin
                    have_size  <= (i_byte != '0);
                    inst_count <= '0;
                    byte_sel   <= '0;
                end
                else
                begin
                    byte_sel <= byte_sel + 1'b1;        // Wraps to 0 after byte 3
                    if (last_byte)
                    begin
                        inst_count <= inst_count + 1'b1;
                        if (last_inst)
                            have_size <= 1'b0;          // Next load starts with size
                    end
                end
            end
        end
    end

    // Size and instruction payload
    always_ff @(posedge i_clk)
    begin
        if (i_byte_valid)
        begin
            if (!have_size)
                prog_size <= i_byte;
            else
                inst_reg[byte_sel * `DU_BYTE_W +: `DU_BYTE_W] <= i_byte;
        end
    end

endmodule

`default_nettype wire

// ==== src/state_dumper.sv ====
/*
 * Sends the processor state to the transmit FIFO, registers 0 to 31 and
 * then the PC, each word least significant byte first. Holds its place
 * while the FIFO is full. o_done marks the last byte written.
 */
`timescale 1ns/1ps
`default_nettype none

`include "debug_unit_macros.svh"

module state_dumper
(
    input  logic                        i_clk,
    input  logic                        i_reset,

    input  logic                        i_start,        // Dump request pulse
    input  logic                        i_tx_full,      // Transmit FIFO full
    input  debug_unit_pkg::word_t       i_reg_read,     // Register at o_addr
    input  debug_unit_pkg::word_t       i_pc,

    output logic                        o_wr,           // Push transmit FIFO
    output debug_unit_pkg::byte_t       o_tx_data,
    output debug_unit_pkg::reg_addr_t   o_addr,         // Register file read address
    output logic                        o_done          // Cycle of the last push
);

    debug_unit_pkg::dump_phase_t    phase;
    debug_unit_pkg::reg_addr_t      addr;
    debug_unit_pkg::byte_sel_t      byte_sel;
    debug_unit_pkg::word_t          cur_word;
    logic                           last_byte;
    logic                           last_reg;

    assign cur_word  = (phase == debug_unit_pkg::DUMP_PC) ? i_pc : i_reg_read;
    assign last_byte = (byte_sel == debug_unit_pkg::byte_sel_t'(`DU_BYTES_PER_WORD - 1));
    assign last_reg  = (addr == debug_unit_pkg::reg_addr_t'(`DU_NUM_REGS - 1));

    assign o_wr      = (phase != debug_unit_pkg::DUMP_IDLE) && !i_tx_full;
    assign o_tx_data = cur_word[byte_sel * `DU_BYTE_W +: `DU_BYTE_W];
    assign o_addr    = addr;
    assign o_done    = o_wr && last_byte && (phase == debug_unit_pkg::DUMP_PC);

    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            phase    <= debug_unit_pkg::DUMP_IDLE;
            addr     <= '0;
            byte_sel <= '0;
        end
        else
        begin
            // Advance only on an accepted byte
            if (o_wr)
                byte_sel <= byte_sel + 1'b1;

            case (phase)
                debug_unit_pkg::DUMP_IDLE:
                begin
                    if (i_start)
                        phase <= debug_unit_pkg::DUMP_REGS;
                end

                debug_unit_pkg::DUMP_REGS:
                begin
                    if (o_wr && last_byte)
                    begin
                        if (last_reg)
                            phase <= debug_unit_pkg::DUMP_PC;   // addr parks on 31
                        else
                            addr <= addr + 1'b1;
                    end
                end

                debug_unit_pkg::DUMP_PC:
                begin
                    if (o_done)
                    begin
                        phase <= debug_unit_pkg::DUMP_IDLE;
                        addr  <= '0;                            // Ready for the next dump
                    end
                end

                default:
                    phase <= debug_unit_pkg::DUMP_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== src/debug_unit.sv ====
/*
 * UART debug unit top. Sits between the UART FIFOs and the pipeline,
 * loading programs, stepping or running the core and dumping its state.
 */
`timescale 1ns/1ps
`default_nettype none

module debug_unit
(
    input  logic                        i_clk,
    input  logic                        i_reset,

    input  logic                        i_rx_empty,     // UART receive FIFO
    input  debug_unit_pkg::byte_t       i_rx_data,
    input  logic                        i_tx_full,      // UART transmit FIFO
    input  logic                        i_halt,         // Pipeline status
    input  debug_unit_pkg::word_t       i_reg_read,
    input  debug_unit_pkg::word_t       i_pc,

    output logic                        o_rd,
    output logic                        o_wr,
    output debug_unit_pkg::byte_t       o_tx_data,
    output logic                        o_write_mem,    // Instruction memory
    output debug_unit_pkg::word_t       o_inst,
    output logic                        o_enable,       // Pipeline control
    output logic                        o_reset,
    output debug_unit_pkg::reg_addr_t   o_addr
);

    logic                   load_byte_valid;
    debug_unit_pkg::byte_t  load_byte;
    logic                   load_done;
    logic                   dump_start;
    logic                   dump_done;

    cmd_sequencer cmd_sequencer_inst
    (
        .i_clk              (i_clk),
        .i_reset            (i_reset),
        .i_rx_empty         (i_rx_empty),
        .i_rx_data          (i_rx_data),
        .i_halt             (i_halt),
        .i_load_done        (load_done),
        .i_dump_done        (dump_done),
        .o_rd               (o_rd),
        .o_load_byte_valid  (load_byte_valid),
        .o_load_byte        (load_byte),
        .o_dump_start       (dump_start),
        .o_enable           (o_enable),
        .o_reset            (o_reset)
    );

    prog_loader prog_loader_inst
    (
        .i_clk              (i_clk),
        .i_reset            (i_reset),
        .i_byte_valid       (load_byte_valid),
        .i_byte             (load_byte),
        .o_load_done        (load_done),
        .o_write_mem        (o_write_mem),
        .o_inst             (o_inst)
    );

    state_dumper state_dumper_inst
    (
        .i_clk              (i_clk),
        .i_reset            (i_reset),
        .i_start            (dump_start),
        .i_tx_full          (i_tx_full),
        .i_reg_read         (i_reg_read),
        .i_pc               (i_pc),
        .o_wr               (o_wr),
        .o_tx_data          (o_tx_data),
        .o_addr             (o_addr),
        .o_done             (dump_done)
    );

endmodule

`default_nettype wire

// ==== dv/debug_unit_props.sv ====
/*
 * Port protocol checks for the debug unit, attached to every
 * debug_unit instance by the bind at the end of this file.
 */
`timescale 1ns/1ps
`default_nettype none

module debug_unit_props
(
    input  logic    i_clk,
    input  logic    i_reset,
    input  logic    i_rx_empty,
    input  logic    i_tx_full,
    input  logic    o_rd,
    input  logic    o_wr,
    input  logic    o_write_mem,
    input  logic    o_enable,
    input  logic    o_reset
);

    tx_not_full: assert property (@(posedge i_clk) disable iff (i_reset)
        !(o_wr && i_tx_full))
        else $error("Transmit write while the transmit FIFO is full");

    rx_not_empty: assert property (@(posedge i_clk) disable iff (i_reset)
        !(o_rd && i_rx_empty))
        else $error("Receive read while the receive FIFO is empty");

    write_mem_pulse: assert property (@(posedge i_clk) disable iff (i_reset)
        o_write_mem |=> !o_write_mem)
        else $error("Instruction memory write held for two cycles");

    reset_pulse: assert property (@(posedge i_clk) disable iff (i_reset)
        o_reset |=> !o_reset)
        else $error("Software reset held for two cycles");

    // Pipeline runs and the dump never overlap
    enable_vs_dump: assert property (@(posedge i_clk) disable iff (i_reset)
        !(o_enable && o_wr))
        else $error("Pipeline enabled while the state dump writes");

endmodule

bind debug_unit debug_unit_props debug_unit_props_inst
(
    .i_clk          (i_clk),
    .i_reset        (i_reset),
    .i_rx_empty     (i_rx_empty),
    .i_tx_full      (i_tx_full),
    .o_rd           (o_rd),
    .o_wr           (o_wr),
    .o_write_mem    (o_write_mem),
    .o_enable       (o_enable),
    .o_reset        (o_reset)
);

`default_nettype wire

// ==== dv/debug_unit_tb.sv ====
/*
 * Testbench for the UART debug unit. Models the receive FIFO, register file
 * and transmit side, applies a table of commands and checks loaded words,
 * enable cycles, dump bytes and software reset pulses of each row.
 */
`timescale 1ns/1ps
`default_nettype none

`include "debug_unit_macros.svh"

module debug_unit_tb;

    localparam int DUMP_BYTES = (`DU_NUM_REGS + 1) * `DU_BYTES_PER_WORD;
    localparam int QUIET      = 24;     // Idle cycles that close a row
    localparam int MARGIN     = 4;      // Slack for back-pressure

    logic                           i_clk;
    logic                           i_reset;
    logic                           i_rx_empty;
    debug_unit_pkg::byte_t          i_rx_data;
    logic                           i_tx_full;
    logic                           i_halt;
    debug_unit_pkg::word_t          i_reg_read;
    debug_unit_pkg::word_t          i_pc;
    logic                           o_rd;
    logic                           o_wr;
    debug_unit_pkg::byte_t          o_tx_data;
    logic                           o_write_mem;
    debug_unit_pkg::word_t          o_inst;
    logic                           o_enable;
    logic                           o_reset;
    debug_unit_pkg::reg_addr_t      o_addr;

    // Test table, one entry per row
    string                          row_name[$];
    debug_unit_pkg::byte_t          row_cmd[$];
    int                             row_size[$];
    int                             row_delay[$];     // Enabled cycles before halt
    bit                             row_rfull[$];
    int                             row_resets[$];
    debug_unit_pkg::word_t          row_pc[$];

    debug_unit_pkg::byte_t          rx_q[$];
    debug_unit_pkg::byte_t          tx_q[$];
    debug_unit_pkg::word_t          inst_q[$];
    debug_unit_pkg::word_t          exp_inst[$];
    int                             enable_count;
    int                             reset_count;
    int                             halt_delay;
    bit                             random_full;
    int                             cycle_count;
    int                             cycle_limit;
    int                             check_count;
    int                             value_errors;
    int                             other_errors;

    debug_unit debug_unit_inst (.*);

    function automatic debug_unit_pkg::word_t reg_pattern(input int index);
        return (index * 32'h0101_0101) ^ 32'hA5A5_A5A5;
    endfunction

    // Byte n of the dump stream
    function automatic debug_unit_pkg::byte_t dump_byte(input int n,
                                                        input debug_unit_pkg::word_t pc);
        debug_unit_pkg::word_t word;
        word = (n / 4 < `DU_NUM_REGS) ? reg_pattern(n / 4) : pc;
        return word[(n % 4) * 8 +: 8];
    endfunction

    always_comb
        i_reg_read = reg_pattern(int'(o_addr));         // Combinational register read

    initial
    begin
        i_clk = 1'b0;
        forever #4 i_clk = ~i_clk;
    end

    // Receive FIFO model
    always @(posedge i_clk)
    begin
        if (o_rd)
        begin
            assert (rx_q.size() != 0)
            else
            begin
                $display("Read strobe seen while the receive FIFO model was empty");
                other_errors++;
            end
            if (rx_q.size() != 0)
                rx_q.delete(0);
        end
        i_rx_empty <= (rx_q.size() == 0);
        i_rx_data  <= (rx_q.size() != 0) ? rx_q[0] : 8'h00;
    end

    // Output capture, halt and back-pressure
    always @(posedge i_clk)
    begin
        if (o_wr)
            tx_q.push_back(o_tx_data);
        if (o_write_mem)
            inst_q.push_back(o_inst);
        if (o_enable)
            enable_count++;
        if (o_reset)
            reset_count++;
        i_halt    <= (enable_count >= halt_delay);
        i_tx_full <= random_full ? 1'($urandom % 2) : 1'b0;
    end

    always @(posedge i_clk)
    begin
        cycle_count++;
        if (cycle_count > cycle_limit)
        begin
            $display("Timeout after %0d cycles, the DUT never went quiet", cycle_count);
            $display("test failed");
            $finish;
        end
    end

    task automatic add_row(input string name, input debug_unit_pkg::byte_t cmd,
                           input int size, input int delay, input bit rfull,
                           input int resets, input debug_unit_pkg::word_t pc);
        row_name.push_back(name);
        row_cmd.push_back(cmd);
        row_size.push_back(size);
        row_delay.push_back(delay);
        row_rfull.push_back(rfull);
        row_resets.push_back(resets);
        row_pc.push_back(pc);
    endtask

    task automatic check_eq(input string test, input string what,
                            input logic [31:0] expected, input logic [31:0] actual);
        check_count++;
        assert (expected === actual)
        else
        begin
            $display("FAIL %s %s: expected %0h, actual %0h", test, what, expected, actual);
            value_errors++;
        end
    endtask

    // Ends after a run of cycles with no DUT activity
    task automatic wait_quiet();
        int idle;
        idle = 0;
        while (idle < QUIET)
        begin
            @(posedge i_clk);
            if (!o_rd && !o_wr && !o_enable && !o_write_mem && !o_reset)
                idle++;
            else
                idle = 0;
        end
    endtask

    task automatic apply_row(input int n);
        debug_unit_pkg::word_t word;
        int exp_enables;
        int exp_bytes;
        @(posedge i_clk);
        tx_q.delete();
        inst_q.delete();
        exp_inst.delete();
        enable_count = 0;
        reset_count  = 0;
        halt_delay   = row_delay[n];
        random_full  = row_rfull[n];
        i_pc        <= row_pc[n];
        @(posedge i_clk);                               // Halt level settles first
        rx_q.push_back(row_cmd[n]);
        if (row_cmd[n] == `DU_CMD_LOAD)
        begin
            rx_q.push_back(8'(row_size[n]));
            for (int i = 0; i < row_size[n]; i++)
            begin
                for (int b = 0; b < `DU_BYTES_PER_WORD; b++)
                begin
                    word[b * 8 +: 8] = 8'($urandom);
                    rx_q.push_back(word[b * 8 +: 8]);
                end
                exp_inst.push_back(word);               // Least significant byte first
            end
        end
        wait_quiet();
        random_full = 1'b0;
        exp_enables = (row_cmd[n] == `DU_CMD_STEP) ? 1 :
                      (row_cmd[n] == `DU_CMD_RUN) ? row_delay[n] : 0;
        exp_bytes   = (exp_enables != 0 || row_cmd[n] == `DU_CMD_RUN) ? DUMP_BYTES : 0;
        check_eq(row_name[n], "write count", exp_inst.size(), inst_q.size());
        for (int i = 0; i < exp_inst.size() && i < inst_q.size(); i++)
            check_eq(row_name[n], $sformatf("instruction %0d", i), exp_inst[i], inst_q[i]);
        check_eq(row_name[n], "enable cycles", exp_enables, enable_count);
        check_eq(row_name[n], "dump length", exp_bytes, tx_q.size());
        for (int i = 0; i < exp_bytes && i < tx_q.size(); i++)
            check_eq(row_name[n], $sformatf("dump byte %0d", i), dump_byte(i, row_pc[n]), tx_q[i]);
        check_eq(row_name[n], "reset pulses", row_resets[n], reset_count);
        check_eq(row_name[n], "bytes left in rx", 0, rx_q.size());
    endtask

    initial
    begin
        void'($urandom(81));
        i_reset      = 1'b1;
        i_rx_empty   = 1'b1;
        i_rx_data    = 8'h00;
        i_tx_full    = 1'b0;
        i_halt       = 1'b0;
        i_pc         = 32'h0;
        halt_delay   = 1;
        random_full  = 1'b0;
        enable_count = 0;
        reset_count  = 0;
        cycle_count  = 0;
        check_count  = 0;
        value_errors = 0;
        other_errors = 0;

        //      name            command          size delay rfull resets pc
        add_row("load_3",       `DU_CMD_LOAD,    3,   1,    0,    0,     32'h0);
        add_row("load_0",       `DU_CMD_LOAD,    0,   1,    0,    0,     32'h0);
        add_row("step",         `DU_CMD_STEP,    0,   1,    0,    0,     32'h0000_0040);
        add_row("step_halt",    `DU_CMD_STEP,    0,   0,    0,    1,     32'h0000_0104);
        add_row("run",          `DU_CMD_RUN,     0,   7,    0,    1,     32'h0000_1F0C);
        add_row("step_bp",      `DU_CMD_STEP,    0,   1,    1,    0,     32'hDEAD_0010);
        add_row("reset_cmd",    `DU_CMD_RESET,   0,   1,    0,    1,     32'h0);
        add_row("unknown",      8'h55,           0,   1,    0,    0,     32'h0);

        cycle_limit = 8;                                // Reset cycles
        for (int n = 0; n < row_name.size(); n++)
            cycle_limit += 8 + 4 * row_size[n] + DUMP_BYTES + row_delay[n] + QUIET;
        cycle_limit *= MARGIN;

        repeat (4) @(posedge i_clk);
        i_reset <= 1'b0;

        for (int n = 0; n < row_name.size(); n++)
            apply_row(n);

        $display("Checks: %0d, value errors: %0d, other errors: %0d",
                 check_count, value_errors, other_errors);
        if (value_errors + other_errors == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== debug_unit.f ====
+incdir+src
src/debug_unit_pkg.sv
src/cmd_sequencer.sv
src/prog_loader.sv
src/state_dumper.sv
src/debug_unit.sv
dv/debug_unit_props.sv
dv/debug_unit_tb.sv
